// File: verilog/lossmon_pkg.sv
package lossmon_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int aux_w = 8;   // sequence byte carried in each frame
	localparam int cnt_w = 32;  // every statistics counter

	// ----------------------------------------
	// stream beats
	// ----------------------------------------
	// one byte of the incoming frame stream
	typedef struct packed {
		logic [7:0] data;  // payload byte
		logic       last;  // final byte of frame
	} rx_beat_t;

	// captured aux, one per frame
	typedef struct packed {
		logic             valid;  // single-cycle strobe
		logic [aux_w-1:0] aux;    // sequence value
	} aux_evt_t;

	// ----------------------------------------
	// results
	// ----------------------------------------
	typedef struct packed {
		logic [cnt_w-1:0] count;  // frames checked
		logic [cnt_w-1:0] ok;     // frames in sequence
		logic [cnt_w-1:0] ng;     // sequence breaks
		logic [cnt_w-1:0] lost;   // estimated missing frames
	} loss_stats_t;

	// checker FSM
	typedef enum logic [1:0] {
		DET_SYNC,  // waiting for first aux, takes it as reference
		DET_RUN,   // checking every event
		DET_DONE   // max_packets reached, events ignored
	} det_state_e;

endpackage

// File: verilog/rx_credit_fifo.sv
module rx_credit_fifo #(
	parameter int fifo_depth = 8
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  lossmon_pkg::rx_beat_t in_beat,
	output logic                  out_valid,
	output lossmon_pkg::rx_beat_t out_beat,
	output logic                  credit
);
	import lossmon_pkg::*;

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int occ_w = $clog2(fifo_depth + 1);  // must hold fifo_depth itself

	rx_beat_t         mem [fifo_depth];  // circular storage
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [occ_w-1:0] occupancy;         // entries held, excl. output reg
	logic             push;
	logic             pop;

	// pointer advance with wrap at fifo_depth, depth need not be 2^n
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(fifo_depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign push = in_valid;            // sender only sends with credit
	assign pop  = (occupancy != '0);   // drain whenever something is held

	// ----------------------------------------
	// storage and output payload
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_beat;
		end
		if (pop) begin
			out_beat <= mem[rd_ptr];  // head into output reg
		end
	end

	// ----------------------------------------
	// pointers, occupancy, credit return
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
			out_valid <= 1'b0;
			credit    <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			// push and pop together leave occupancy unchanged
			occupancy <= occupancy + occ_w'(push) - occ_w'(pop);
			out_valid <= pop;
			credit    <= pop;  // one credit per byte on the output
		end
	end

endmodule

// File: verilog/aux_extract.sv
module aux_extract #(
	parameter int aux_pos = 0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  lossmon_pkg::rx_beat_t in_beat,
	output lossmon_pkg::aux_evt_t evt
);

	logic [15:0] byte_idx;  // position of current beat in its frame
	logic        hit;       // this beat is the aux byte

	assign hit = in_valid && (byte_idx == 16'(aux_pos));

	// ----------------------------------------
	// byte position and aux capture
	// ----------------------------------------
	always_ff @(posedge clk) begin
		// captured byte, qualified by evt.valid
		if (hit) begin
			evt.aux <= in_beat.data;
		end

		if (rst) begin
			byte_idx  <= '0;
			evt.valid <= 1'b0;
		end else begin
			evt.valid <= hit;  // one cycle per frame at most
			if (in_valid) begin
				if (in_beat.last) begin
					byte_idx <= '0;  // next beat starts a new frame
				end else if (byte_idx != '1) begin
					// saturate so giant frames cannot alias back onto aux_pos
					byte_idx <= byte_idx + 1'b1;
				end
			end
		end
	end

	// frame ending before aux_pos never reaches the compare, no event

endmodule

// File: verilog/loss_detector.sv
module loss_detector #(
	parameter int seg_max     = 4,
	parameter int max_packets = 500000
) (
	input  logic                     clk,
	input  logic                     rst,
	input  lossmon_pkg::aux_evt_t    evt,
	output lossmon_pkg::loss_stats_t stats,
	output logic                     done
);
	import lossmon_pkg::*;

	localparam int sc_w = 16;  // frames-within-group counter

	det_state_e       state;
	logic [aux_w-1:0] aux_prev;   // last aux seen
	logic [sc_w-1:0]  samecount;  // index of that frame in its group
	logic [aux_w-1:0] aux_exp;
	logic [aux_w-1:0] aux_gap;    // whole groups skipped
	logic             grp_end;
	logic             match;
	logic             take;       // event accepted this cycle
	logic [cnt_w-1:0] count_nxt;

	// lost pipeline
	logic             s1_valid;
	logic [aux_w-1:0] s1_gap;
	logic [cnt_w-1:0] s1_rem;     // frames missing from the broken group
	logic             s2_valid;
	logic [cnt_w-1:0] s2_term;

	assign grp_end   = (samecount == sc_w'(seg_max - 1));
	assign aux_exp   = grp_end ? aux_prev + 1'b1 : aux_prev;  // wraps 255 -> 0
	assign match     = (evt.aux == aux_exp);
	assign aux_gap   = evt.aux - aux_prev - 1'b1;  // mod 256 by width
	assign take      = evt.valid && (state != DET_DONE);
	assign count_nxt = stats.count + 1'b1;

	// ----------------------------------------
	// sequence check FSM and counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= DET_SYNC;
			samecount <= '0;
			stats     <= '0;
			done      <= 1'b0;
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
		end else begin
			s1_valid <= 1'b0;
			case (state)
				DET_SYNC: begin
					if (evt.valid) begin
						// first aux is the reference, counts as good
						samecount   <= '0;
						stats.count <= count_nxt;
						stats.ok    <= stats.ok + 1'b1;
						state       <= DET_RUN;
					end
				end
				DET_RUN: begin
					if (evt.valid) begin
						stats.count <= count_nxt;
						if (match) begin
							stats.ok  <= stats.ok + 1'b1;
							samecount <= grp_end ? '0 : samecount + 1'b1;
						end else begin
							stats.ng  <= stats.ng + 1'b1;
							samecount <= '0;   // event opens a fresh group
							s1_valid  <= 1'b1; // loss estimate in flight
						end
					end
				end
				default: begin
					// DET_DONE, hold totals
				end
			endcase

			// finish on the event that reaches max_packets
			if (take && count_nxt == cnt_w'(max_packets)) begin
				state <= DET_DONE;
				done  <= 1'b1;
			end

			// retire losses even after done
			s2_valid <= s1_valid;
			if (s2_valid) begin
				stats.lost <= stats.lost + s2_term;
			end
		end
	end

	// ----------------------------------------
	// reference byte and loss datapath
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (take) begin
			aux_prev <= evt.aux;  // both on match and on break
		end
		// stage 1, old aux_prev and samecount still in place here
		if (take && state == DET_RUN && !match) begin
			s1_gap <= aux_gap;
			s1_rem <= cnt_w'(seg_max - 1) - cnt_w'(samecount);
		end
		// stage 2
		if (s1_valid) begin
			s2_term <= cnt_w'(s1_gap) * cnt_w'(seg_max) + s1_rem;
		end
	end

endmodule

// File: verilog/lossmon_top.sv
module lossmon_top #(
	parameter int fifo_depth  = 8,
	parameter int aux_pos     = 0,
	parameter int seg_max     = 4,
	parameter int max_packets = 500000
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     in_valid,
	input  lossmon_pkg::rx_beat_t    in_beat,
	output logic                     credit,
	output lossmon_pkg::loss_stats_t stats,
	output logic                     done
);
	import lossmon_pkg::*;

	logic     fifo_valid;  // buffered byte stream
	rx_beat_t fifo_beat;
	aux_evt_t evt;         // one per frame

	// ----------------------------------------
	// credit buffer -> extractor -> checker
	// ----------------------------------------
	rx_credit_fifo #(
		.fifo_depth (fifo_depth)
	) u_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_beat   (in_beat),
		.out_valid (fifo_valid),
		.out_beat  (fifo_beat),
		.credit    (credit)
	);

	aux_extract #(
		.aux_pos (aux_pos)
	) u_extract (
		.clk      (clk),
		.rst      (rst),
		.in_valid (fifo_valid),
		.in_beat  (fifo_beat),
		.evt      (evt)
	);

	loss_detector #(
		.seg_max     (seg_max),
		.max_packets (max_packets)
	) u_detect (
		.clk   (clk),
		.rst   (rst),
		.evt   (evt),
		.stats (stats),
		.done  (done)
	);

endmodule

// File: verif/lossmon_properties.sv
module lossmon_properties #(
	parameter int fifo_depth = 8
) (
	input logic                             clk,
	input logic                             rst,
	input logic                             in_valid,
	input logic                             credit,
	input logic [$clog2(fifo_depth+1)-1:0]  fifo_occ,
	input logic                             evt_valid,
	input logic [lossmon_pkg::cnt_w-1:0]    frame_count,
	input lossmon_pkg::det_state_e          det_state
);
	timeunit 1ns;
	timeprecision 1ps;
	import lossmon_pkg::*;

	int held;  // credits the sender holds right now

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= fifo_depth;
		end else begin
			held <= held + int'(credit) - int'(in_valid);
		end
	end

	// ----------------------------------------
	// credit and stream rules
	// ----------------------------------------
	a_send_with_credit: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> held > 0)
		else $error("byte sent while the sender held no credit");

	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		held <= fifo_depth)
		else $error("more credits returned than bytes sent");

	a_fifo_bound: assert property (@(posedge clk) disable iff (rst)
		int'(fifo_occ) <= fifo_depth)
		else $error("fifo occupancy above its depth");

	a_evt_single: assert property (@(posedge clk) disable iff (rst)
		evt_valid |=> !evt_valid)
		else $error("aux event held for two cycles");

	// finished checker ignores later events
	a_done_holds: assert property (@(posedge clk) disable iff (rst)
		det_state == DET_DONE |=> $stable(frame_count))
		else $error("frame count moved after the checker finished");

endmodule

bind lossmon_top lossmon_properties #(
	.fifo_depth (fifo_depth)
) u_props (
	.clk         (clk),
	.rst         (rst),
	.in_valid    (in_valid),
	.credit      (credit),
	.fifo_occ    (u_fifo.occupancy),
	.evt_valid   (evt.valid),
	.frame_count (stats.count),
	.det_state   (u_detect.state)
);

// File: verif/lossmon_tb.sv
module lossmon_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import lossmon_pkg::*;

	localparam int fifo_depth  = 8;
	localparam int aux_pos     = 1;
	localparam int seg_max     = 3;
	localparam int max_packets = 20;
	localparam int n_rows      = 23;
	localparam int wait_limit  = 200;  // cycles allowed per wait loop

	// frame to send plus totals expected once it has gone through
	typedef struct packed {
		logic [7:0]  aux;
		logic [7:0]  len;    // bytes in frame
		logic        gap;    // random idle cycles before frame
		logic [31:0] count;
		logic [31:0] ok;
		logic [31:0] ng;
		logic [31:0] lost;
		logic        done;
	} frame_row_t;

	logic        clk;
	logic        rst;
	logic        in_valid;
	rx_beat_t    in_beat;
	logic        credit;
	loss_stats_t stats;
	logic        done;

	frame_row_t rows [n_rows];
	int         credits;  // sender side, starts at fifo_depth
	integer     seed;

	// reference model state
	bit m_synced;
	bit m_done;
	int m_prev;
	int m_same;  // position of last frame in its group
	int m_count;
	int m_ok;
	int m_ng;
	int m_lost;

	lossmon_top #(
		.fifo_depth  (fifo_depth),
		.aux_pos     (aux_pos),
		.seg_max     (seg_max),
		.max_packets (max_packets)
	) u_dut (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_beat  (in_beat),
		.credit   (credit),
		.stats    (stats),
		.done     (done)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// spend one per byte sent, regain one per credit pulse
	always @(posedge clk) begin
		if (rst) begin
			credits <= fifo_depth;
		end else begin
			credits <= credits + int'(credit) - int'(in_valid);
		end
	end

	// ----------------------------------------
	// table
	// ----------------------------------------
	function automatic frame_row_t make_row(input int aux, input int len, input bit gap,
			input int count, input int ok, input int ng, input int lost, input bit fin);
		frame_row_t r;
		r.aux   = 8'(aux);
		r.len   = 8'(len);
		r.gap   = gap;
		r.count = 32'(count);
		r.ok    = 32'(ok);
		r.ng    = 32'(ng);
		r.lost  = 32'(lost);
		r.done  = fin;
		return r;
	endfunction

	task automatic load_table;
		rows[0]  = make_row(0,   3,  1, 1,  1,  0, 0,    0);  // first aux, sync
		rows[1]  = make_row(0,   2,  1, 2,  2,  0, 0,    0);
		rows[2]  = make_row(0,   4,  1, 3,  3,  0, 0,    0);
		rows[3]  = make_row(1,   2,  1, 4,  4,  0, 0,    0);  // next group
		rows[4]  = make_row(1,   3,  1, 5,  5,  0, 0,    0);
		rows[5]  = make_row(1,   5,  1, 6,  6,  0, 0,    0);
		rows[6]  = make_row(2,   3,  1, 7,  7,  0, 0,    0);
		rows[7]  = make_row(4,   3,  1, 8,  7,  1, 5,    0);  // group 3 skipped, 2 + 1*3
		rows[8]  = make_row(4,   2,  1, 9,  8,  1, 5,    0);
		rows[9]  = make_row(5,   3,  1, 10, 8,  2, 6,    0);  // break inside group, 1 lost
		rows[10] = make_row(255, 4,  1, 11, 8,  3, 755,  0);  // 2 + 249*3
		rows[11] = make_row(255, 2,  1, 12, 9,  3, 755,  0);
		rows[12] = make_row(255, 2,  1, 13, 10, 3, 755,  0);
		rows[13] = make_row(0,   3,  1, 14, 11, 3, 755,  0);  // 255 -> 0 in sequence
		rows[14] = make_row(254, 3,  1, 15, 11, 4, 1516, 0);  // 2 + 253*3
		rows[15] = make_row(1,   3,  1, 16, 11, 5, 1524, 0);  // 254 -> 1, 2 + 2*3
		rows[16] = make_row(9,   1,  1, 16, 11, 5, 1524, 0);  // too short, no event
		rows[17] = make_row(1,   12, 0, 17, 12, 5, 1524, 0);  // longer than the fifo
		rows[18] = make_row(1,   12, 0, 18, 13, 5, 1524, 0);
		rows[19] = make_row(2,   10, 0, 19, 14, 5, 1524, 0);
		rows[20] = make_row(3,   9,  0, 20, 14, 6, 1526, 1);  // 20th frame, loss retires late
		rows[21] = make_row(3,   3,  1, 20, 14, 6, 1526, 1);  // ignored after done
		rows[22] = make_row(7,   2,  1, 20, 14, 6, 1526, 1);
	endtask

	// ----------------------------------------
	// checks and waits
	// ----------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#1;  // drive just after the edge
	endtask

	task automatic send_byte(input logic [7:0] data, input logic last);
		int tries;
		tries = 0;
		while (credits == 0) begin
			in_valid = 1'b0;  // hold off, no credit
			if (tries == wait_limit) begin
				fail_run("timeout: sender waited too long for a credit to come back");
			end
			next_cycle();
			tries++;
		end
		in_valid     = 1'b1;
		in_beat.data = data;
		in_beat.last = last;
		next_cycle();
	endtask

	task automatic send_frame(input logic [7:0] aux, input int len);
		logic [7:0] data;
		for (int i = 0; i < len; i++) begin
			data = (i == aux_pos) ? aux : 8'($random(seed));  // filler bytes random
			send_byte(data, i == len - 1);
		end
		in_valid = 1'b0;
	endtask

	// all credits home means the fifo and its output reg are empty
	task automatic wait_drained;
		int tries;
		tries = 0;
		while (credits != fifo_depth) begin
			if (tries == wait_limit) begin
				fail_run("timeout: fifo did not drain and return all credits");
			end
			next_cycle();
			tries++;
		end
	endtask

	task automatic wait_count(input logic [31:0] exp);
		int tries;
		tries = 0;
		while (stats.count !== exp) begin
			if (tries == wait_limit) begin
				fail_run("timeout: frame count never reached its expected value");
			end
			next_cycle();
			tries++;
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	task automatic model_frame(input int aux, input int len);
		int exp_aux;
		if (len > aux_pos && !m_done) begin
			if (!m_synced) begin
				m_synced = 1'b1;  // first aux taken as reference
				m_same   = 0;
				m_ok++;
			end else begin
				exp_aux = (m_same == seg_max - 1) ? (m_prev + 1) % 256 : m_prev;
				if (aux == exp_aux) begin
					m_ok++;
					m_same = (m_same == seg_max - 1) ? 0 : m_same + 1;
				end else begin
					m_ng++;
					m_lost += (seg_max - m_same - 1)
						+ ((aux - m_prev - 1 + 256) % 256) * seg_max;
					m_same = 0;
				end
			end
			m_count++;
			m_prev = aux;
			m_done = (m_count == max_packets);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int idle;
		seed     = 32'h8916;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_beat  = '0;
		m_synced = 1'b0;
		m_done   = 1'b0;
		m_prev   = 0;
		m_same   = 0;
		m_count  = 0;
		m_ok     = 0;
		m_ng     = 0;
		m_lost   = 0;
		load_table();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 0; r < n_rows; r++) begin
			if (rows[r].gap) begin
				idle = int'($unsigned($random(seed)) % 4);
				repeat (idle) next_cycle();
			end
			send_frame(rows[r].aux, int'(rows[r].len));

			// hand-worked table against the model
			model_frame(int'(rows[r].aux), int'(rows[r].len));
			check_value($sformatf("model count row %0d", r), 32'(m_count), rows[r].count);
			check_value($sformatf("model ok row %0d", r), 32'(m_ok), rows[r].ok);
			check_value($sformatf("model ng row %0d", r), 32'(m_ng), rows[r].ng);
			check_value($sformatf("model lost row %0d", r), 32'(m_lost), rows[r].lost);

			wait_drained();
			wait_count(rows[r].count);
			repeat (4) next_cycle();  // lets the lost pipeline retire

			check_value($sformatf("stats.count row %0d", r), stats.count, rows[r].count);
			check_value($sformatf("stats.ok row %0d", r), stats.ok, rows[r].ok);
			check_value($sformatf("stats.ng row %0d", r), stats.ng, rows[r].ng);
			check_value($sformatf("stats.lost row %0d", r), stats.lost, rows[r].lost);
			check_value($sformatf("done row %0d", r), 32'(done), 32'(rows[r].done));
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: build.f
verilog/lossmon_pkg.sv
verilog/rx_credit_fifo.sv
verilog/aux_extract.sv
verilog/loss_detector.sv
verilog/lossmon_top.sv
verif/lossmon_properties.sv
verif/lossmon_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lossmon_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
